// File: verilog/win_pkg.sv
package win_pkg;

    // Pixel and position widths
    localparam int PIX_W = 8;
    localparam int POS_W = 10;  // Up to 1024 rows or columns

    typedef logic [PIX_W-1:0] pixel_t;

    // Control FSM states
    typedef enum logic [1:0] {
        FILL   = 2'd0,  // Window still loading
        STREAM = 2'd1   // One window per beat
    } ctrl_state_t;

endpackage

// File: verilog/win_ctrl_fsm.sv
`timescale 1ns/100ps

module win_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic valid_i,
    input  logic fill_full_i,
    input  logic frame_end_i,
    output logic fill_step_o,
    output logic emit_o
);

    import win_pkg::*;

    ctrl_state_t state;
    logic        frame_wrap;

    assign frame_wrap = emit_o && frame_end_i;  // Last window of the frame leaving

    // A beat that meets the last emit already belongs to the next frame
    assign fill_step_o = valid_i && (state == FILL || frame_wrap);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= FILL;
            emit_o <= 1'b0;
        end else begin
            emit_o <= 1'b0;
            if (fill_step_o) begin
                if (fill_full_i) begin
                    state  <= STREAM;
                    emit_o <= 1'b1;  // First centre of the frame
                end else begin
                    state <= FILL;
                end
            end else if (frame_wrap) begin
                state <= FILL;
            end else if (valid_i) begin
                emit_o <= 1'b1;  // Only reachable in STREAM
            end
        end
    end

    emit_in_stream_a: assert property (@(posedge clk) disable iff (rst)
        emit_o |-> state == STREAM && $past(valid_i))
        else $error("emit without a streamed beat");

endmodule

// File: verilog/win_position.sv
`timescale 1ns/100ps

module win_position #(
    parameter int WIN  = 5,
    parameter int ROWS = 6,
    parameter int COLS = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fill_step_i,
    input  logic                      emit_i,
    output logic                      fill_full_o,
    output logic [win_pkg::POS_W-1:0] row_o,
    output logic [win_pkg::POS_W-1:0] col_o,
    output logic                      frame_end_o
);

    import win_pkg::*;

    localparam int HALF = WIN / 2;

    logic [POS_W-1:0] fill_cnt;
    logic [POS_W-1:0] fill_now;
    logic             frame_wrap;

    assign frame_end_o = (row_o == POS_W'(ROWS - 1)) && (col_o == POS_W'(COLS - 1));
    assign frame_wrap  = emit_i && frame_end_o;
    assign fill_now    = frame_wrap ? '0 : fill_cnt;  // Restart for the next frame
    assign fill_full_o = (fill_now == POS_W'(HALF));

    // Fill count holds at HALF while streaming
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt <= '0;
        end else if (fill_step_i && !fill_full_o) begin
            fill_cnt <= fill_now + 1'b1;
        end else begin
            fill_cnt <= fill_now;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_o <= '0;
            col_o <= '0;
        end else if (emit_i) begin
            if (col_o == POS_W'(COLS - 1)) begin
                col_o <= '0;
                row_o <= (row_o == POS_W'(ROWS - 1)) ? '0 : row_o + 1'b1;
            end else begin
                col_o <= col_o + 1'b1;
            end
        end
    end

    pos_range_a: assert property (@(posedge clk) disable iff (rst)
        row_o < POS_W'(ROWS) && col_o < POS_W'(COLS))
        else $error("centre outside image");

endmodule

// File: verilog/win_shift.sv
`timescale 1ns/100ps

module win_shift #(
    parameter int WIN = 5
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           valid_i,
    input  win_pkg::pixel_t [WIN-1:0]      column_i,
    output win_pkg::pixel_t [WIN*WIN-1:0]  window_o
);

    // Tap i*WIN+j is row i, column j; column 0 is the oldest
    always_ff @(posedge clk) begin
        if (rst) begin
            window_o <= '0;
        end else if (valid_i) begin
            for (int i = 0; i < WIN; i++) begin
                for (int j = 0; j < WIN - 1; j++) begin
                    window_o[i*WIN + j] <= window_o[i*WIN + j + 1];
                end
                window_o[i*WIN + WIN - 1] <= column_i[i];  // Newest column enters right
            end
        end
    end

    column_known_a: assert property (@(posedge clk) disable iff (rst)
        valid_i |-> !$isunknown(column_i))
        else $error("unknown pixel on accepted beat");

endmodule

// File: verilog/win_pad_mask.sv
`timescale 1ns/100ps

module win_pad_mask #(
    parameter int WIN  = 5,
    parameter int ROWS = 6,
    parameter int COLS = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          emit_i,
    input  win_pkg::pixel_t [WIN*WIN-1:0] window_i,
    input  logic [win_pkg::POS_W-1:0]     row_i,
    input  logic [win_pkg::POS_W-1:0]     col_i,
    input  logic                          frame_end_i,
    output logic                          valid_o,
    output win_pkg::pixel_t [WIN*WIN-1:0] window_o,
    output logic                          frame_done_o
);

    localparam int HALF = WIN / 2;

    logic [WIN-1:0] row_in;
    logic [WIN-1:0] col_in;

    // Tap offset k maps to image index pos+k-HALF
    always_comb begin
        for (int k = 0; k < WIN; k++) begin
            row_in[k] = (int'(row_i) + k >= HALF) && (int'(row_i) + k < ROWS + HALF);
            col_in[k] = (int'(col_i) + k >= HALF) && (int'(col_i) + k < COLS + HALF);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o      <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            valid_o      <= emit_i;
            frame_done_o <= emit_i && frame_end_i;
        end
    end

    always_ff @(posedge clk) begin
        if (emit_i) begin
            for (int i = 0; i < WIN; i++) begin
                for (int j = 0; j < WIN; j++) begin
                    window_o[i*WIN + j] <= (row_in[i] && col_in[j]) ?
                                           window_i[i*WIN + j] : '0;  // Zero padding
                end
            end
        end
    end

    // Done strobe must come with the window of the bottom-right centre
    done_at_last_a: assert property (@(posedge clk) disable iff (rst)
        frame_done_o |-> valid_o && int'($past(row_i)) == ROWS - 1
                         && int'($past(col_i)) == COLS - 1)
        else $error("frame done away from the last centre");

endmodule

// File: verilog/win_gen_top.sv
`timescale 1ns/100ps

module win_gen_top #(
    parameter int WIN  = 5,
    parameter int ROWS = 6,
    parameter int COLS = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid_i,
    input  win_pkg::pixel_t [WIN-1:0]     column_i,
    output logic                          valid_o,
    output win_pkg::pixel_t [WIN*WIN-1:0] window_o,
    output logic                          frame_done_o
);

    import win_pkg::*;

    logic                   fill_step;
    logic                   emit;
    logic                   fill_full;
    logic                   frame_end;
    logic [POS_W-1:0]       row;
    logic [POS_W-1:0]       col;
    pixel_t [WIN*WIN-1:0]   window;  // Unmasked window

    win_ctrl_fsm win_ctrl_fsm_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .fill_full_i (fill_full),
        .frame_end_i (frame_end),
        .fill_step_o (fill_step),
        .emit_o      (emit)
    );

    win_position #(.WIN(WIN), .ROWS(ROWS), .COLS(COLS)) win_position_i (
        .clk         (clk),
        .rst         (rst),
        .fill_step_i (fill_step),
        .emit_i      (emit),
        .fill_full_o (fill_full),
        .row_o       (row),
        .col_o       (col),
        .frame_end_o (frame_end)
    );

    win_shift #(.WIN(WIN)) win_shift_i (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (valid_i),
        .column_i (column_i),
        .window_o (window)
    );

    win_pad_mask #(.WIN(WIN), .ROWS(ROWS), .COLS(COLS)) win_pad_mask_i (
        .clk          (clk),
        .rst          (rst),
        .emit_i       (emit),
        .window_i     (window),
        .row_i        (row),
        .col_i        (col),
        .frame_end_i  (frame_end),
        .valid_o      (valid_o),
        .window_o     (window_o),
        .frame_done_o (frame_done_o)
    );

endmodule

// File: tests/win_tb.sv
`timescale 1ns/100ps

module win_tb;

    import win_pkg::*;

    localparam int WIN         = 5;
    localparam int ROWS        = 6;
    localparam int COLS        = 8;
    localparam int HALF        = WIN / 2;
    localparam int FRAME_BEATS = HALF + ROWS * COLS;
    localparam int TOTAL_BEATS = 4 * FRAME_BEATS;  // Plain, gapped, two back to back
    localparam int MAX_CYCLES  = 2 * TOTAL_BEATS + 100;

    typedef pixel_t [WIN*WIN-1:0] window_t;
    typedef pixel_t [WIN-1:0]     column_t;

    logic    clk;
    logic    rst;
    logic    valid_i;
    column_t column_i;
    logic    valid_o;
    window_t window_o;
    logic    frame_done_o;

    integer  seed = 32'h795f;
    string   test_name = "reset";
    int      errors;
    int      tests_ok;
    int      tests_bad;
    int      win_count;
    int      done_count;
    int      cycles;

    column_t hist [WIN];  // Age 0 is the newest column
    int      beat_cnt;
    logic    s1_valid;
    logic    s1_done;
    window_t s1_window;
    window_t s1_pad;
    logic    exp_valid;
    logic    exp_done;
    window_t exp_window;
    window_t exp_pad;

    win_gen_top #(.WIN(WIN), .ROWS(ROWS), .COLS(COLS)) win_gen_top_i (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (valid_i),
        .column_i     (column_i),
        .valid_o      (valid_o),
        .window_o     (window_o),
        .frame_done_o (frame_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d cycles in %s", cycles, test_name);
        $display("Test failed");
        $finish;
    end

    // Window for centre (r, c) from the column history, plus the padded taps
    function automatic void expected_window(input int r, input int c,
                                            output window_t w, output window_t pad);
        int ri;
        int ci;
        for (int i = 0; i < WIN; i++) begin
            for (int j = 0; j < WIN; j++) begin
                ri = r + i - HALF;
                ci = c + j - HALF;
                if (ri < 0 || ri >= ROWS || ci < 0 || ci >= COLS) begin
                    w[i*WIN + j]   = '0;
                    pad[i*WIN + j] = '1;
                end else begin
                    w[i*WIN + j]   = hist[WIN-1-j][i];  // Column j is WIN-1-j beats old
                    pad[i*WIN + j] = '0;
                end
            end
        end
    endfunction

    // Reference model, two stages to line up with valid_o
    always @(posedge clk) begin : model
        window_t w;
        window_t pad;
        int      centre;
        if (rst) begin
            for (int a = 0; a < WIN; a++) begin
                hist[a] = '0;
            end
            beat_cnt   <= 0;
            s1_valid   <= 1'b0;
            s1_done    <= 1'b0;
            s1_window  <= '0;
            s1_pad     <= '0;
            exp_valid  <= 1'b0;
            exp_done   <= 1'b0;
            exp_window <= '0;
            exp_pad    <= '0;
        end else begin
            s1_valid <= 1'b0;
            s1_done  <= 1'b0;
            if (valid_i) begin
                for (int a = WIN - 1; a > 0; a--) begin
                    hist[a] = hist[a-1];
                end
                hist[0] = column_i;
                if (beat_cnt >= HALF) begin  // Past the fill
                    centre = beat_cnt - HALF;
                    expected_window(centre / COLS, centre % COLS, w, pad);
                    s1_valid  <= 1'b1;
                    s1_done   <= (centre == ROWS * COLS - 1);
                    s1_window <= w;
                    s1_pad    <= pad;
                end
                beat_cnt <= (beat_cnt == FRAME_BEATS - 1) ? 0 : beat_cnt + 1;
            end
            exp_valid  <= s1_valid;
            exp_done   <= s1_done;
            exp_window <= s1_window;
            exp_pad    <= s1_pad;
        end
    end

    always @(posedge clk) begin
        if (!rst && valid_o) begin
            win_count <= win_count + 1;
        end
        if (!rst && frame_done_o) begin
            done_count <= done_count + 1;
        end
    end

    valid_a: assert property (@(posedge clk) disable iff (rst) valid_o == exp_valid)
        else begin
            errors++;
            $display("error %s valid_o expected %0b actual %0b", test_name,
                     $sampled(exp_valid), $sampled(valid_o));
        end

    window_a: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> (window_o & ~exp_pad) == (exp_window & ~exp_pad))
        else begin
            errors++;
            $display("error %s window expected %h actual %h", test_name,
                     $sampled(exp_window & ~exp_pad), $sampled(window_o & ~exp_pad));
        end

    padding_a: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> (window_o & exp_pad) == '0)
        else begin
            errors++;
            $display("error %s padding expected %h actual %h", test_name,
                     window_t'(0), $sampled(window_o & exp_pad));
        end

    done_a: assert property (@(posedge clk) disable iff (rst) frame_done_o == exp_done)
        else begin
            errors++;
            $display("error %s frame_done_o expected %0b actual %0b", test_name,
                     $sampled(exp_done), $sampled(frame_done_o));
        end

    task automatic check_count(input string name, input string what,
                               input int expected, input int actual);
        if (actual != expected) begin
            errors++;
            $display("error %s %s expected %0d actual %0d", name, what, expected, actual);
        end
    endtask

    // Sends whole frames, then waits for the frame done strobes
    task automatic run_test(input string name, input int frames, input bit gaps);
        int      err_start;
        int      win_start;
        int      done_start;
        int      sent;
        column_t col;
        test_name  = name;
        err_start  = errors;
        win_start  = win_count;
        done_start = done_count;
        sent       = 0;
        while (sent < frames * FRAME_BEATS) begin
            @(posedge clk);
            for (int i = 0; i < WIN; i++) begin
                col[i] = pixel_t'($random(seed));
            end
            column_i <= col;  // Idle cycles carry junk too
            if (gaps && ({$random(seed)} % 3 == 0)) begin
                valid_i <= 1'b0;
            end else begin
                valid_i <= 1'b1;
                sent++;
            end
        end
        @(posedge clk);
        valid_i <= 1'b0;
        while (done_count - done_start < frames) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        check_count(name, "window count", frames * ROWS * COLS, win_count - win_start);
        check_count(name, "frame done count", frames, done_count - done_start);
        if (errors == err_start) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        rst      = 1'b1;
        valid_i  = 1'b0;
        column_i = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        run_test("reset_fill", 1, 1'b0);
        run_test("stream_gaps", 1, 1'b1);
        run_test("back_to_back", 2, 1'b0);
        $display("counts: %0d pass, %0d fail, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
verilog/win_pkg.sv
verilog/win_ctrl_fsm.sv
verilog/win_position.sv
verilog/win_shift.sv
verilog/win_pad_mask.sv
verilog/win_gen_top.sv
tests/win_tb.sv

// File: Makefile
# Verilator build and run for the window generator testbench

VERILATOR ?= verilator
TOP       ?= win_tb
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
